// ==== logic/trapPkg.sv ====
// trap package with CSR addresses, access and cause types, field positions and timer map
`default_nettype none

package trapPkg;

    // register width of the hart
    localparam int XLEN = 64;

    // machine-mode CSR addresses handled by the CSR file
    typedef enum logic [11:0] {
        csrMstatus  = 12'h300,
        csrMie      = 12'h304,
        csrMtvec    = 12'h305,
        csrMscratch = 12'h340,
        csrMepc     = 12'h341,
        csrMcause   = 12'h342,
        csrMip      = 12'h344
    } csrAddrE;

    // csrNone is a plain read
    typedef enum logic [1:0] {
        csrNone,
        csrWrite,
        csrSet,
        csrClear
    } csrOpE;

    // encoded directly as the mcause value
    typedef enum logic [XLEN-1:0] {
        causeEcall = 64'h0000_0000_0000_000b,
        causeTimer = 64'h8000_0000_0000_0007
    } trapCauseE;

    // mstatus, mie and mip field positions
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;
    localparam int MTIE_BIT = 7;
    localparam int MTIP_BIT = 7;

    // MPP = machine, all else zero
    localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h0000_0000_0000_1800;

    // timer register offsets on the APB port
    localparam logic [3:0] MTIME_LO    = 4'h0;
    localparam logic [3:0] MTIME_HI    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO = 4'h8;
    localparam logic [3:0] MTIMECMP_HI = 4'hc;

endpackage

`default_nettype wire

// ==== logic/trapIf.sv ====
// trap interface carrying trap events and CSR state between trap unit and CSR file
`timescale 1ns/100ps
`default_nettype none

interface trapIf;

    // events raised by the trap unit
    logic                          trapEnter;
    trapPkg::trapCauseE            trapCause;
    logic [trapPkg::XLEN-1:0]      trapEpc;
    logic                          trapReturn;

    // state exported by the CSR file
    logic [trapPkg::XLEN-1:0]      mtvec;
    logic [trapPkg::XLEN-1:0]      mepc;
    logic                          globalIe;
    logic                          timerIe;

    modport trapSide (
        output trapEnter, trapCause, trapEpc, trapReturn,
        input  mtvec, mepc, globalIe, timerIe
    );

    modport csrSide (
        input  trapEnter, trapCause, trapEpc, trapReturn,
        output mtvec, mepc, globalIe, timerIe
    );

endinterface

`default_nettype wire

// ==== logic/csrFile.sv ====
// machine CSR file with write/set/clear access, read mux and trap entry/return updates
`timescale 1ns/100ps
`default_nettype none

module csrFile (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire trapPkg::csrOpE           csrOp,
    input  wire logic [11:0]              csrAddr,
    input  wire logic [trapPkg::XLEN-1:0] csrWdata,
    output logic [trapPkg::XLEN-1:0]      csrRdata,
    input  wire logic                     timerPending,
    trapIf.csrSide                        trap
);

    logic [trapPkg::XLEN-1:0] mstatus;
    logic [trapPkg::XLEN-1:0] mie;
    logic [trapPkg::XLEN-1:0] mtvec;
    logic [trapPkg::XLEN-1:0] mscratch;
    logic [trapPkg::XLEN-1:0] mepc;
    logic [trapPkg::XLEN-1:0] mcause;
    logic [trapPkg::XLEN-1:0] mip;

    logic [trapPkg::XLEN-1:0] csrNew;
    logic                     csrWr;
    logic [trapPkg::XLEN-1:0] mipNext;

    // combinational read, unknown addresses return zero
    always_comb begin
        case (csrAddr)
            trapPkg::csrMstatus:  csrRdata = mstatus;
            trapPkg::csrMie:      csrRdata = mie;
            trapPkg::csrMtvec:    csrRdata = mtvec;
            trapPkg::csrMscratch: csrRdata = mscratch;
            trapPkg::csrMepc:     csrRdata = mepc;
            trapPkg::csrMcause:   csrRdata = mcause;
            trapPkg::csrMip:      csrRdata = mip;
            default:              csrRdata = '0;
        endcase
    end

    // new value built from the currently read value
    always_comb begin
        case (csrOp)
            trapPkg::csrWrite: csrNew = csrWdata;
            trapPkg::csrSet:   csrNew = csrRdata | csrWdata;
            trapPkg::csrClear: csrNew = csrRdata & ~csrWdata;
            trapPkg::csrNone:  csrNew = csrRdata;
        endcase
    end

    assign csrWr = (csrOp != trapPkg::csrNone);

    // MTIP is owned by the timer, other bits by software
    always_comb begin
        mipNext = mip;
        if (csrWr && csrAddr == trapPkg::csrMip) begin
            mipNext = csrNew;
        end
        mipNext[trapPkg::MTIP_BIT] = timerPending;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= trapPkg::MSTATUS_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mip      <= '0;
        end else begin
            mip <= mipNext;

            // trap events win over software writes
            if (trap.trapEnter) begin
                mstatus[trapPkg::MPIE_BIT]     <= mstatus[trapPkg::MIE_BIT];
                mstatus[trapPkg::MIE_BIT]      <= 1'b0;
                mstatus[trapPkg::MPP_LO +: 2]  <= 2'b11;
            end else if (trap.trapReturn) begin
                mstatus[trapPkg::MIE_BIT]  <= mstatus[trapPkg::MPIE_BIT];
                mstatus[trapPkg::MPIE_BIT] <= 1'b1;
            end else if (csrWr && csrAddr == trapPkg::csrMstatus) begin
                mstatus <= csrNew;
            end

            if (trap.trapEnter) begin
                mepc <= trap.trapEpc;
            end else if (csrWr && csrAddr == trapPkg::csrMepc) begin
                mepc <= csrNew;
            end

            if (trap.trapEnter) begin
                mcause <= trap.trapCause;
            end else if (csrWr && csrAddr == trapPkg::csrMcause) begin
                mcause <= csrNew;
            end

            if (csrWr && csrAddr == trapPkg::csrMie) begin
                mie <= csrNew;
            end
            if (csrWr && csrAddr == trapPkg::csrMtvec) begin
                mtvec <= csrNew;
            end
            if (csrWr && csrAddr == trapPkg::csrMscratch) begin
                mscratch <= csrNew;
            end
        end
    end

    // state seen by the trap unit
    assign trap.mtvec    = mtvec;
    assign trap.mepc     = mepc;
    assign trap.globalIe = mstatus[trapPkg::MIE_BIT];
    assign trap.timerIe  = mie[trapPkg::MTIE_BIT];

    // entry and return share mstatus, so the trap unit must not raise both
    trapStrobesExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(trap.trapEnter && trap.trapReturn)
    );

    csrOpKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(csrOp)
    );

endmodule

`default_nettype wire

// ==== logic/trapUnit.sv ====
// trap unit deciding interrupt, ecall or mret and driving the redirect target
`timescale 1ns/100ps
`default_nettype none

module trapUnit (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     ecall,
    input  wire logic                     mret,
    input  wire logic [trapPkg::XLEN-1:0] pc,
    input  wire logic                     timerPending,
    output logic                          redirectValid,
    output logic [trapPkg::XLEN-1:0]      redirectPc,
    trapIf.trapSide                       trap
);

    logic takeIrq;
    logic enterHit;
    logic returnHit;

    // interrupt needs pending, global enable and the timer enable
    assign takeIrq = timerPending && trap.globalIe && trap.timerIe;

    // priority is timer, then ecall, then mret
    assign enterHit  = takeIrq || ecall;
    assign returnHit = !enterHit && mret;

    assign trap.trapEnter  = enterHit;
    assign trap.trapReturn = returnHit;
    assign trap.trapCause  = takeIrq ? trapPkg::causeTimer : trapPkg::causeEcall;
    assign trap.trapEpc    = pc;

    // traps jump to mtvec (direct mode), mret back to mepc
    assign redirectValid = enterHit || returnHit;
    assign redirectPc    = enterHit ? trap.mtvec : trap.mepc;

    redirectOneStrobe: assert property (
        @(posedge clk) disable iff (rst)
        redirectValid |-> $onehot({trap.trapEnter, trap.trapReturn})
    );

    // MIE drops in the CSR file after entry, so a held pending traps once
    timerTrapOnce: assert property (
        @(posedge clk) disable iff (rst)
        (trap.trapEnter && trap.trapCause == trapPkg::causeTimer)
        |=> !(trap.trapEnter && trap.trapCause == trapPkg::causeTimer)
    );

endmodule

`default_nettype wire

// ==== logic/clintTimer.sv ====
// core-local timer with mtime/mtimecmp on APB and a registered pending level
`timescale 1ns/100ps
`default_nettype none

module clintTimer (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [3:0]  paddr,
    input  wire logic [31:0] pwdata,
    output logic [31:0]      prdata,
    output logic             timerPending
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [63:0] mtimeInc;
    logic        apbAccess;
    logic        apbWrite;

    // zero-wait slave, every access cycle completes
    assign apbAccess = psel && penable;
    assign apbWrite  = apbAccess && pwrite;

    assign mtimeInc = mtime + 64'd1;

    // written half loads as is, the other half keeps counting
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (apbWrite && paddr == trapPkg::MTIME_LO) begin
            mtime <= {mtimeInc[63:32], pwdata};
        end else if (apbWrite && paddr == trapPkg::MTIME_HI) begin
            mtime <= {pwdata, mtimeInc[31:0]};
        end else begin
            mtime <= mtimeInc;
        end
    end

    // all ones keeps the compare quiet until software programs it
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (apbWrite && paddr == trapPkg::MTIMECMP_LO) begin
            mtimecmp[31:0] <= pwdata;
        end else if (apbWrite && paddr == trapPkg::MTIMECMP_HI) begin
            mtimecmp[63:32] <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            timerPending <= 1'b0;
        end else begin
            timerPending <= (mtime >= mtimecmp);
        end
    end

    // read data only during a read access cycle
    always_comb begin
        prdata = '0;
        if (apbAccess && !pwrite) begin
            case (paddr)
                trapPkg::MTIME_LO:    prdata = mtime[31:0];
                trapPkg::MTIME_HI:    prdata = mtime[63:32];
                trapPkg::MTIMECMP_LO: prdata = mtimecmp[31:0];
                trapPkg::MTIMECMP_HI: prdata = mtimecmp[63:32];
                default:              prdata = '0;
            endcase
        end
    end

    apbEnableNeedsSel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    );

    // a setup cycle is always followed by its access cycle
    apbSetupThenAccess: assert property (
        @(posedge clk) disable iff (rst)
        (psel && !penable) |=> (psel && penable)
    );

endmodule

`default_nettype wire

// ==== logic/trapTop.sv ====
// trap subsystem top level joining CSR file, trap unit and timer to plain ports
`timescale 1ns/100ps
`default_nettype none

module trapTop (
    input  wire logic                     clk,
    input  wire logic                     rst,

    // CSR access from the core
    input  wire trapPkg::csrOpE           csrOp,
    input  wire logic [11:0]              csrAddr,
    input  wire logic [trapPkg::XLEN-1:0] csrWdata,
    output logic [trapPkg::XLEN-1:0]      csrRdata,

    // instruction events
    input  wire logic                     ecall,
    input  wire logic                     mret,
    input  wire logic [trapPkg::XLEN-1:0] pc,

    // fetch redirect
    output logic                          redirectValid,
    output logic [trapPkg::XLEN-1:0]      redirectPc,

    // APB to the timer registers
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire logic [3:0]               paddr,
    input  wire logic [31:0]              pwdata,
    output logic [31:0]                   prdata
);

    logic timerPending;

    trapIf trapBus ();

    csrFile uCsrFile (
        .clk          (clk),
        .rst          (rst),
        .csrOp        (csrOp),
        .csrAddr      (csrAddr),
        .csrWdata     (csrWdata),
        .csrRdata     (csrRdata),
        .timerPending (timerPending),
        .trap         (trapBus.csrSide)
    );

    trapUnit uTrapUnit (
        .clk           (clk),
        .rst           (rst),
        .ecall         (ecall),
        .mret          (mret),
        .pc            (pc),
        .timerPending  (timerPending),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .trap          (trapBus.trapSide)
    );

    clintTimer uClintTimer (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .timerPending (timerPending)
    );

endmodule

`default_nettype wire

// ==== verif/trapTopTb.sv ====
// testbench stepping the trap subsystem through a table of CSR, APB, event and trap-wait rows
`timescale 1ns/100ps
`default_nettype none

module trapTopTb;

    typedef enum {rowCsr, rowApb, rowEvent, rowWait} rowKindE;
    typedef enum {checkNone, checkEq, checkGreater, checkRel} checkE;

    typedef struct {
        rowKindE     kind;
        logic [1:0]  op;
        logic [11:0] addr;
        logic [63:0] data;
        logic [63:0] expVal;
        checkE       check;
        string       name;
    } rowT;

    // slots of the shadow CSR model
    localparam int mstatusIdx = 0;
    localparam int mieIdx = 1;
    localparam int mtvecIdx = 2;
    localparam int mscratchIdx = 3;
    localparam int mepcIdx = 4;
    localparam int mcauseIdx = 5;
    localparam int mipIdx = 6;

    logic clk, rst, ecall, mret, redirectValid, psel, penable, pwrite;
    trapPkg::csrOpE csrOp;
    logic [11:0] csrAddr;
    logic [63:0] csrWdata, csrRdata, pc, redirectPc;
    logic [3:0]  paddr;
    logic [31:0] pwdata, prdata;

    rowT         rows[$];
    logic [63:0] model[7];
    logic [63:0] curPc;
    logic [31:0] lastRead;
    int          rowErrors, passCount, failCount;

    trapTop DUT (.*);

    always #50 clk = ~clk;

    function automatic int csrIndex(logic [11:0] addr);
        case (addr)
            12'h300: return mstatusIdx;
            12'h304: return mieIdx;
            12'h305: return mtvecIdx;
            12'h340: return mscratchIdx;
            12'h341: return mepcIdx;
            12'h342: return mcauseIdx;
            12'h344: return mipIdx;
            default: return -1;
        endcase
    endfunction

    // reference model of write, OR-set and AND-NOT-clear
    // unknown addresses read 0
    task automatic addCsr(string name, trapPkg::csrOpE op, logic [11:0] addr, logic [63:0] data);
        int idx;
        logic [63:0] newVal;
        idx = csrIndex(addr);
        newVal = '0;
        if (idx >= 0) begin
            case (op)
                trapPkg::csrWrite: newVal = data;
                trapPkg::csrSet:   newVal = model[idx] | data;
                trapPkg::csrClear: newVal = model[idx] & ~data;
                default:           newVal = model[idx];
            endcase
            model[idx] = newVal;
        end
        rows.push_back('{rowCsr, op, addr, data, newVal, checkEq, name});
    endtask

    task automatic addApb(string name, logic wr, logic [3:0] addr, logic [31:0] data,
                          checkE check, logic [31:0] expVal);
        rows.push_back('{rowApb, {1'b0, wr}, {8'h0, addr}, {32'h0, data}, {32'h0, expVal},
                         check, name});
    endtask

    task automatic modelEnter(logic [63:0] cause);
        model[mepcIdx] = curPc;
        model[mcauseIdx] = cause;
        model[mstatusIdx][trapPkg::MPIE_BIT] = model[mstatusIdx][trapPkg::MIE_BIT];
        model[mstatusIdx][trapPkg::MIE_BIT] = 1'b0;
        model[mstatusIdx][trapPkg::MPP_LO +: 2] = 2'b11;
    endtask

    // op 0 is ecall, op 1 is mret
    task automatic addEvent(string name, logic isMret, logic [63:0] pcVal);
        logic [63:0] target;
        curPc = pcVal;
        if (!isMret) begin
            target = model[mtvecIdx];
            modelEnter(64'd11);
        end else begin
            target = model[mepcIdx];
            model[mstatusIdx][trapPkg::MIE_BIT] = model[mstatusIdx][trapPkg::MPIE_BIT];
            model[mstatusIdx][trapPkg::MPIE_BIT] = 1'b1;
        end
        rows.push_back('{rowEvent, {1'b0, isMret}, 12'h0, pcVal, target, checkEq, name});
    endtask

    // timer trap expected within the given cycles, or silence for that long
    task automatic addWait(string name, logic expectTrap, int cycles);
        logic [63:0] target;
        target = model[mtvecIdx];
        if (expectTrap) begin
            modelEnter({1'b1, 63'd7});
            model[mipIdx][trapPkg::MTIP_BIT] = 1'b1;
        end
        rows.push_back('{rowWait, {1'b0, expectTrap}, 12'h0, 64'(cycles), target, checkEq, name});
    endtask

    task automatic buildRows();
        logic [11:0] regs[4];
        logic [31:0] cmpLo, cmpHi;
        regs = '{trapPkg::csrMtvec, trapPkg::csrMscratch, trapPkg::csrMie, trapPkg::csrMepc};
        model = '{trapPkg::MSTATUS_RESET, 0, 0, 0, 0, 0, 0};
        curPc = '0;
        addCsr("mstatus reset", trapPkg::csrNone, trapPkg::csrMstatus, '0);
        foreach (regs[k]) addCsr("csr write", trapPkg::csrWrite, regs[k], {$urandom, $urandom});
        foreach (regs[k]) addCsr("csr set", trapPkg::csrSet, regs[k], {$urandom, $urandom});
        foreach (regs[k]) addCsr("csr clear", trapPkg::csrClear, regs[k], {$urandom, $urandom});
        addCsr("unknown write", trapPkg::csrWrite, 12'h7c0, {$urandom, $urandom});
        addCsr("unknown read", trapPkg::csrNone, 12'h7c0, '0);
        addCsr("mscratch kept", trapPkg::csrNone, trapPkg::csrMscratch, '0);
        addCsr("enable MIE", trapPkg::csrSet, trapPkg::csrMstatus, 64'h8);
        addEvent("ecall", 1'b0, {$urandom, $urandom} & ~64'h3);
        addCsr("ecall mepc", trapPkg::csrNone, trapPkg::csrMepc, '0);
        addCsr("ecall mcause", trapPkg::csrNone, trapPkg::csrMcause, '0);
        addCsr("ecall mstatus", trapPkg::csrNone, trapPkg::csrMstatus, '0);
        // mret pc differs from mepc so the target must come from mepc
        addEvent("mret", 1'b1, {$urandom, $urandom} & ~64'h3);
        addCsr("mret mstatus", trapPkg::csrNone, trapPkg::csrMstatus, '0);
        // quiet the interrupt path before arming the compare
        addCsr("mie off", trapPkg::csrWrite, trapPkg::csrMie, '0);
        addCsr("MIE off", trapPkg::csrClear, trapPkg::csrMstatus, 64'h8);
        addApb("mtimecmp hi zero", 1'b1, trapPkg::MTIMECMP_HI, '0, checkNone, '0);
        addApb("mtime first", 1'b0, trapPkg::MTIME_LO, '0, checkNone, '0);
        addApb("mtime grows", 1'b0, trapPkg::MTIME_LO, '0, checkGreater, '0);
        addApb("mtimecmp lo near", 1'b1, trapPkg::MTIMECMP_LO, 32'd20, checkRel, '0);
        addCsr("MTIE on", trapPkg::csrSet, trapPkg::csrMie, 64'h80);
        addCsr("MIE on", trapPkg::csrSet, trapPkg::csrMstatus, 64'h8);
        addWait("timer trap", 1'b1, 200);
        addCsr("timer mcause", trapPkg::csrNone, trapPkg::csrMcause, '0);
        addCsr("timer mip", trapPkg::csrNone, trapPkg::csrMip, '0);
        addCsr("timer mstatus", trapPkg::csrNone, trapPkg::csrMstatus, '0);
        addWait("no second trap", 1'b0, 30);
        addCsr("MTIE off", trapPkg::csrClear, trapPkg::csrMie, 64'h80);
        addCsr("MIE on again", trapPkg::csrSet, trapPkg::csrMstatus, 64'h8);
        addWait("masked timer", 1'b0, 50);
        cmpLo = $urandom;
        cmpHi = $urandom;
        addApb("mtimecmp lo write", 1'b1, trapPkg::MTIMECMP_LO, cmpLo, checkNone, '0);
        addApb("mtimecmp hi write", 1'b1, trapPkg::MTIMECMP_HI, cmpHi, checkNone, '0);
        addApb("mtimecmp lo read", 1'b0, trapPkg::MTIMECMP_LO, '0, checkEq, cmpLo);
        addApb("mtimecmp hi read", 1'b0, trapPkg::MTIMECMP_HI, '0, checkEq, cmpHi);
    endtask

    task automatic checkValue(string sig, logic [63:0] expVal, logic [63:0] got);
        assert (got === expVal) else begin
            $display("FAIL time=%0t %s expected 0x%h actual 0x%h", $time, sig, expVal, got);
            rowErrors++;
        end
    endtask

    // op lands at the next edge and the read-back is sampled mid-cycle after it
    task automatic csrAccess(trapPkg::csrOpE op, logic [11:0] addr, logic [63:0] data,
                             output logic [63:0] rdata);
        @(posedge clk);
        csrOp <= op;
        csrAddr <= addr;
        csrWdata <= data;
        if (op != trapPkg::csrNone) begin
            @(posedge clk);
            csrOp <= trapPkg::csrNone;
        end
        @(negedge clk);
        rdata = csrRdata;
    endtask

    // setup then access cycle with read data taken during access
    task automatic apbTransfer(logic wr, logic [3:0] addr, logic [31:0] data,
                               output logic [31:0] rdata);
        @(posedge clk);
        psel <= 1'b1;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic eventPulse(logic isMret, logic [63:0] pcVal, output logic valid,
                              output logic [63:0] target);
        @(posedge clk);
        ecall <= !isMret;
        mret <= isMret;
        pc <= pcVal;
        @(negedge clk);
        valid = redirectValid;
        target = redirectPc;
        @(posedge clk);
        ecall <= 1'b0;
        mret <= 1'b0;
    endtask

    task automatic waitRedirect(int limit, output logic seen, output logic [63:0] target);
        int n;
        seen = 1'b0;
        target = '0;
        n = 0;
        while (!seen && n < limit) begin
            @(negedge clk);
            if (redirectValid) begin
                seen = 1'b1;
                target = redirectPc;
            end
            n++;
        end
    endtask

    task automatic runRow(rowT r);
        logic [63:0] got;
        logic [31:0] apbData;
        logic        flag;
        case (r.kind)
            rowCsr: begin
                csrAccess(trapPkg::csrOpE'(r.op), r.addr, r.data, got);
                checkValue("csrRdata", r.expVal, got);
            end
            rowApb: begin
                apbData = (r.check == checkRel) ? lastRead + r.data[31:0] : r.data[31:0];
                apbTransfer(r.op[0], r.addr[3:0], apbData, got[31:0]);
                if (r.check == checkEq) checkValue("prdata", r.expVal, {32'h0, got[31:0]});
                if (r.check == checkGreater) begin
                    assert (got[31:0] > lastRead) else begin
                        $display("FAIL time=%0t prdata expected above 0x%h actual 0x%h",
                                 $time, lastRead, got[31:0]);
                        rowErrors++;
                    end
                end
                if (!r.op[0]) lastRead = got[31:0];
            end
            rowEvent: begin
                eventPulse(r.op[0], r.data, flag, got);
                checkValue("redirectValid", 64'd1, {63'd0, flag});
                checkValue("redirectPc", r.expVal, got);
            end
            default: begin
                waitRedirect(int'(r.data), flag, got);
                if (r.op[0]) begin
                    assert (flag) else begin
                        $display("timeout: no redirect within %0d cycles", r.data);
                        rowErrors++;
                    end
                    if (flag) checkValue("redirectPc", r.expVal, got);
                end else begin
                    assert (!flag) else begin
                        $display("unexpected redirect to 0x%h at time %0t", got, $time);
                        rowErrors++;
                    end
                end
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'h2070c90c));
        clk = 1'b0;
        rst = 1'b1;
        csrOp = trapPkg::csrNone;
        csrAddr = '0;
        csrWdata = '0;
        {ecall, mret, psel, penable, pwrite} = '0;
        pc = '0;
        paddr = '0;
        pwdata = '0;
        lastRead = '0;
        passCount = 0;
        failCount = 0;
        buildRows();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            rowErrors = 0;
            runRow(rows[i]);
            if (rowErrors == 0) passCount++;
            else failCount++;
            $display("test %0d %s: %s", i, rows[i].name, (rowErrors == 0) ? "passed" : "failed");
        end
        $display("tests %0d, passed %0d, failed %0d", rows.size(), passCount, failCount);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/trapPkg.sv
logic/trapIf.sv
logic/csrFile.sv
logic/trapUnit.sv
logic/clintTimer.sv
logic/trapTop.sv
verif/trapTopTb.sv

// ==== Bender.yml ====
package:
  name: trapsys

sources:
  - files:
      - logic/trapPkg.sv
      - logic/trapIf.sv
      - logic/csrFile.sv
      - logic/trapUnit.sv
      - logic/clintTimer.sv
      - logic/trapTop.sv
  - target: test
    files:
      - verif/trapTopTb.sv
